// File: build.f
rtl/rv_pkg.sv
rtl/instr_mem.sv
rtl/fetch_unit.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/data_mem.sv
rtl/riscv_top.sv
sim/riscv_assert.sv
sim/tb_riscv.sv

// File: rtl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem import rv_pkg::*; (
    input  logic            clk,
    input  mem_req_t        i_req,
    output logic [XLEN-1:0] o_rdata
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    assign o_rdata = mem[i_req.addr];    // same-cycle read

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (i_req.strb[i]) begin
                mem[i_req.addr][8*i +: 8] <= i_req.wdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import rv_pkg::*; (
    input  decoded_t              i_dec,
    input  logic [XLEN-1:0]       i_rs1_data,
    input  logic [XLEN-1:0]       i_rs2_data,
    input  logic [XLEN-1:0]       i_load_data,
    output mem_req_t              o_mem_req,
    output logic                  o_rd_we,
    output logic [REG_ADDR_W-1:0] o_rd,
    output logic [XLEN-1:0]       o_rd_data,
    output logic                  o_jump,
    output logic [XLEN-1:0]       o_jump_addr,
    output logic                  o_uart_valid,
    output logic [7:0]            o_uart_data
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] opb;         // reg or imm operand
    logic [XLEN-1:0] addr;        // byte address for lw/sw/sb
    logic            taken;
    logic            is_uart;
    logic [3:0]      strb;
    op_t             op;

    assign op   = i_dec.op;
    assign a    = i_rs1_data;
    assign b    = i_rs2_data;
    assign opb  = (op inside {OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU,
                              OP_SLLI, OP_SRLI, OP_SRAI}) ? i_dec.imm : b;
    assign addr = a + i_dec.imm;

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI:   o_rd_data = a + opb;
            OP_SUB:            o_rd_data = a - b;
            OP_AND, OP_ANDI:   o_rd_data = a & opb;
            OP_OR, OP_ORI:     o_rd_data = a | opb;
            OP_XOR, OP_XORI:   o_rd_data = a ^ opb;
            OP_SLL, OP_SLLI:   o_rd_data = a << opb[4:0];
            OP_SRL, OP_SRLI:   o_rd_data = a >> opb[4:0];
            OP_SRA, OP_SRAI:   o_rd_data = $signed(a) >>> opb[4:0];
            OP_SLT, OP_SLTI:   o_rd_data = {31'b0, $signed(a) < $signed(opb)};
            OP_SLTU, OP_SLTIU: o_rd_data = {31'b0, a < opb};
            OP_LUI:            o_rd_data = i_dec.imm;
            OP_AUIPC:          o_rd_data = i_dec.pc + i_dec.imm;
            OP_JAL, OP_JALR:   o_rd_data = i_dec.pc_plus4;    // link
            OP_LW:             o_rd_data = i_load_data;
            default:           o_rd_data = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLT:  taken = ($signed(a) < $signed(b));
            OP_BGE:  taken = ($signed(a) >= $signed(b));
            OP_BLTU: taken = (a < b);
            OP_BGEU: taken = (a >= b);
            default: taken = 1'b0;
        endcase
    end

    assign o_rd_we = !(op inside {OP_NOP, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU,
                                  OP_BGEU, OP_SW, OP_SB});
    assign o_rd    = i_dec.rd;

    assign o_jump      = taken || (op == OP_JAL) || (op == OP_JALR);
    assign o_jump_addr = (op == OP_JALR) ? (addr & ~32'd1) : (i_dec.pc + i_dec.imm);

    // uart store bypasses data memory
    assign is_uart      = (op == OP_SB) && (addr == UART_TX_ADDR);
    assign o_uart_valid = is_uart;
    assign o_uart_data  = is_uart ? b[7:0] : 8'h00;

    always_comb begin
        case (op)
            OP_SW:   strb = 4'b1111;
            OP_SB:   strb = is_uart ? 4'b0000 : (4'b0001 << addr[1:0]);
            default: strb = 4'b0000;
        endcase
    end

    assign o_mem_req = '{addr:  addr[DMEM_AW+1:2],
                         strb:  strb,
                         wdata: (op == OP_SB) ? {4{b[7:0]}} : b};    // byte in every lane

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_load_en,
    input  logic [IMEM_AW-1:0] i_load_addr,
    input  logic [XLEN-1:0]    i_load_data,
    input  logic               i_jump,
    input  logic [XLEN-1:0]    i_jump_addr,
    output fetch_t             o_fetch
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4_q;
    logic            valid_q;
    logic [XLEN-1:0] instr;

    assign pc_plus4 = pc + 32'd4;

    instr_mem u_imem (
        .clk     (clk),
        .i_we    (i_load_en & reset),    // loading only while held in reset
        .i_waddr (i_load_addr),
        .i_wdata (i_load_data),
        .i_raddr (pc[IMEM_AW+1:2]),
        .o_rdata (instr)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= i_jump ? i_jump_addr : pc_plus4;
        end
    end

    // memory output is the instr half of the fetch/execute register
    always_ff @(posedge clk) begin
        pc_q       <= pc;
        pc_plus4_q <= pc_plus4;
        valid_q    <= !(reset || i_jump);    // squash slot behind a jump
    end

    assign o_fetch = '{instr: instr, pc: pc_q, pc_plus4: pc_plus4_q, valid: valid_q};

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import rv_pkg::*; (
    input  fetch_t   i_fetch,
    output decoded_t o_dec
);

    logic [XLEN-1:0] ins;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;
    op_t             op;

    assign ins    = i_fetch.instr;
    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];
    assign funct7 = ins[31:25];

    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {ins[31:12], 12'h000};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        op  = OP_NOP;
        imm = '0;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: op = OP_ADD;
                    {F7_ALT,  3'b000}: op = OP_SUB;
                    {F7_BASE, 3'b001}: op = OP_SLL;
                    {F7_BASE, 3'b010}: op = OP_SLT;
                    {F7_BASE, 3'b011}: op = OP_SLTU;
                    {F7_BASE, 3'b100}: op = OP_XOR;
                    {F7_BASE, 3'b101}: op = OP_SRL;
                    {F7_ALT,  3'b101}: op = OP_SRA;
                    {F7_BASE, 3'b110}: op = OP_OR;
                    {F7_BASE, 3'b111}: op = OP_AND;
                    default:           op = OP_NOP;
                endcase
            end
            OPC_OP_IMM: begin
                imm = imm_i;    // shifts use the low 5 bits as shamt
                case (funct3)
                    3'b000:  op = OP_ADDI;
                    3'b010:  op = OP_SLTI;
                    3'b011:  op = OP_SLTIU;
                    3'b100:  op = OP_XORI;
                    3'b110:  op = OP_ORI;
                    3'b111:  op = OP_ANDI;
                    3'b001:  op = (funct7 == F7_BASE) ? OP_SLLI : OP_NOP;
                    default: op = (funct7 == F7_BASE) ? OP_SRLI :
                                  (funct7 == F7_ALT)  ? OP_SRAI : OP_NOP;
                endcase
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_NOP;
                endcase
            end
            OPC_LOAD: begin
                imm = imm_i;
                op  = (funct3 == 3'b010) ? OP_LW : OP_NOP;    // lw only
            end
            OPC_STORE: begin
                imm = imm_s;
                op  = (funct3 == 3'b000) ? OP_SB :
                      (funct3 == 3'b010) ? OP_SW : OP_NOP;
            end
            OPC_JALR: begin
                imm = imm_i;
                op  = (funct3 == 3'b000) ? OP_JALR : OP_NOP;
            end
            OPC_JAL: begin
                imm = imm_j;
                op  = OP_JAL;
            end
            OPC_LUI: begin
                imm = imm_u;
                op  = OP_LUI;
            end
            OPC_AUIPC: begin
                imm = imm_u;
                op  = OP_AUIPC;
            end
            default: op = OP_NOP;
        endcase
    end

    assign o_dec = '{op:       i_fetch.valid ? op : OP_NOP,    // flushed slot
                     rd:       ins[11:7],
                     rs1:      ins[19:15],
                     rs2:      ins[24:20],
                     imm:      imm,
                     pc:       i_fetch.pc,
                     pc_plus4: i_fetch.pc_plus4};

endmodule

`default_nettype wire

// File: rtl/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem import rv_pkg::*; (
    input  logic               clk,
    input  logic               i_we,
    input  logic [IMEM_AW-1:0] i_waddr,
    input  logic [XLEN-1:0]    i_wdata,
    input  logic [IMEM_AW-1:0] i_raddr,
    output logic [XLEN-1:0]    o_rdata
);

    logic [XLEN-1:0] mem [IMEM_WORDS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;    // program load
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    output logic [XLEN-1:0]       o_rs1_data,
    output logic [XLEN-1:0]       o_rs2_data,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [XLEN-1:0]       i_wdata
);

    logic [XLEN-1:0] regs [1:31];    // x0 has no storage

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk) begin
        if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/riscv_top.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_top import rv_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_load_en,
    input  logic [IMEM_AW-1:0] i_load_addr,
    input  logic [XLEN-1:0]    i_load_data,
    output logic               o_uart_valid,
    output logic [7:0]         o_uart_data
);

    fetch_t                fetch;
    decoded_t              dec;
    mem_req_t              mem_req;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       load_data;
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rd_data;
    logic                  jump;
    logic [XLEN-1:0]       jump_addr;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_jump      (jump),
        .i_jump_addr (jump_addr),
        .o_fetch     (fetch)
    );

    inst_decoder u_dec (
        .i_fetch (fetch),
        .o_dec   (dec)
    );

    reg_file u_rf (
        .clk        (clk),
        .i_rs1      (dec.rs1),
        .i_rs2      (dec.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (rd_we),
        .i_rd       (rd),
        .i_wdata    (rd_data)
    );

    execute_unit u_exec (
        .i_dec        (dec),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_load_data  (load_data),
        .o_mem_req    (mem_req),
        .o_rd_we      (rd_we),
        .o_rd         (rd),
        .o_rd_data    (rd_data),
        .o_jump       (jump),
        .o_jump_addr  (jump_addr),
        .o_uart_valid (o_uart_valid),
        .o_uart_data  (o_uart_data)
    );

    data_mem u_dmem (
        .clk     (clk),
        .i_req   (mem_req),
        .o_rdata (load_data)
    );

endmodule

`default_nettype wire

// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = 8;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    localparam logic [XLEN-1:0] UART_TX_ADDR = 32'h20020;   // uart transmit byte

    // base opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // sub / sra / srai

    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
        OP_SLTIU, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LW, OP_SW, OP_SB
    } op_t;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_plus4;
        logic            valid;
    } fetch_t;

    typedef struct packed {
        op_t                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_plus4;
    } decoded_t;

    typedef struct packed {
        logic [DMEM_AW-1:0] addr;     // word index
        logic [3:0]         strb;
        logic [XLEN-1:0]    wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: sim/riscv_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_assert import rv_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic [XLEN-1:0] pc,
    input logic            i_jump,
    input fetch_t          o_fetch
);

    int unsigned fail_count = 0;    // read by the testbench at the end

    a_reset_pc: assert property (@(posedge clk) reset |=> (pc == '0))
        else begin
            fail_count++;
            $error("pc not zero after a reset cycle");
        end

    // slot behind a taken jump is squashed
    a_jump_flush: assert property (@(posedge clk) disable iff (reset) i_jump |=> !o_fetch.valid)
        else begin
            fail_count++;
            $error("fetch slot still valid after a jump");
        end

    a_pc_align: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc not word aligned");
        end

endmodule

bind fetch_unit fetch_assert u_fetch_chk (
    .clk     (clk),
    .reset   (reset),
    .pc      (pc),
    .i_jump  (i_jump),
    .o_fetch (o_fetch)
);

`default_nettype wire

// File: sim/tb_riscv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv import rv_pkg::*; ();

    localparam int MAX_ROWS     = 80;
    localparam int RESET_CYCLES = 8;
    localparam int UART_TIMEOUT = 64;    // cycles between two bytes
    localparam int END_WINDOW   = 40;

    logic               clk = 1'b0;
    logic               reset;
    logic               i_load_en;
    logic [IMEM_AW-1:0] i_load_addr;
    logic [XLEN-1:0]    i_load_data;
    logic               o_uart_valid;
    logic [7:0]         o_uart_data;

    logic [31:0] row_word [MAX_ROWS];
    string       row_label [MAX_ROWS];
    bit          row_emit [MAX_ROWS];
    logic [7:0]  row_byte [MAX_ROWS];
    int          n_rows = 0;
    int          n_expected = 0;
    int          strobes = 0;
    int          checks = 0;
    int          errors = 0;

    riscv_top uut (
        .clk          (clk),
        .reset        (reset),
        .i_load_en    (i_load_en),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .o_uart_valid (o_uart_valid),
        .o_uart_data  (o_uart_data)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (o_uart_valid === 1'b1) begin
            strobes++;
        end
    end

    // rv32i encodings
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    // sb rs2, 32(x31) with x31 = 0x20000
    function automatic logic [31:0] to_uart(input logic [4:0] rs2);
        return s_type(3'b000, 5'd31, rs2, 12'h020);
    endfunction

    task automatic add_row(input string label, input logic [31:0] word, input bit emit,
                           input logic [7:0] exp);
        row_label[n_rows] = label;
        row_word[n_rows]  = word;
        row_emit[n_rows]  = emit;
        row_byte[n_rows]  = exp;
        n_rows++;
        if (emit) begin
            n_expected++;
        end
    endtask

    // x1 = 100 and x2 = -3 throughout the program
    task automatic build_program();
        add_row("lui x31",    u_type(7'h37, 5'd31, 20'h00020), 1'b0, 8'h00);
        add_row("addi x1",    i_type(7'h13, 3'b000, 5'd1, 5'd0, 12'd100), 1'b0, 8'h00);
        add_row("addi x2",    i_type(7'h13, 3'b000, 5'd2, 5'd0, 12'hFFD), 1'b0, 8'h00);
        add_row("add",        r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 1'b0, 8'h00);
        add_row("uart add",   to_uart(5'd3), 1'b1, 8'h61);
        add_row("sub",        r_type(7'h20, 3'b000, 5'd3, 5'd1, 5'd2), 1'b0, 8'h00);
        add_row("uart sub",   to_uart(5'd3), 1'b1, 8'h67);
        add_row("xor",        r_type(7'h00, 3'b100, 5'd3, 5'd1, 5'd2), 1'b0, 8'h00);
        add_row("uart xor",   to_uart(5'd3), 1'b1, 8'h99);
        add_row("slt",        r_type(7'h00, 3'b010, 5'd3, 5'd2, 5'd1), 1'b0, 8'h00);
        add_row("uart slt",   to_uart(5'd3), 1'b1, 8'h01);
        add_row("sltu",       r_type(7'h00, 3'b011, 5'd3, 5'd2, 5'd1), 1'b0, 8'h00);
        add_row("uart sltu",  to_uart(5'd3), 1'b1, 8'h00);
        add_row("sll",        r_type(7'h00, 3'b001, 5'd3, 5'd1, 5'd1), 1'b0, 8'h00);
        add_row("uart sll",   to_uart(5'd3), 1'b1, 8'h40);
        add_row("srai 28",    i_type(7'h13, 3'b101, 5'd3, 5'd2, 12'h41C), 1'b0, 8'h00);
        add_row("uart srai",  to_uart(5'd3), 1'b1, 8'hFF);
        add_row("srli 28",    i_type(7'h13, 3'b101, 5'd3, 5'd2, 12'h01C), 1'b0, 8'h00);
        add_row("uart srli",  to_uart(5'd3), 1'b1, 8'h0F);
        add_row("slti",       i_type(7'h13, 3'b010, 5'd3, 5'd2, 12'd5), 1'b0, 8'h00);
        add_row("uart slti",  to_uart(5'd3), 1'b1, 8'h01);
        add_row("sltiu",      i_type(7'h13, 3'b011, 5'd3, 5'd2, 12'd5), 1'b0, 8'h00);
        add_row("uart sltiu", to_uart(5'd3), 1'b1, 8'h00);
        add_row("andi",       i_type(7'h13, 3'b111, 5'd3, 5'd2, 12'h0F0), 1'b0, 8'h00);
        add_row("uart andi",  to_uart(5'd3), 1'b1, 8'hF0);
        add_row("beq taken",  b_type(3'b000, 5'd1, 5'd1, 13'd8), 1'b0, 8'h00);
        add_row("marker",     to_uart(5'd2), 1'b0, 8'h00);
        add_row("bne fall",   b_type(3'b001, 5'd1, 5'd1, 13'd8), 1'b0, 8'h00);
        add_row("uart x1",    to_uart(5'd1), 1'b1, 8'h64);
        add_row("blt taken",  b_type(3'b100, 5'd2, 5'd1, 13'd8), 1'b0, 8'h00);
        add_row("marker",     to_uart(5'd2), 1'b0, 8'h00);
        add_row("bltu fall",  b_type(3'b110, 5'd2, 5'd1, 13'd8), 1'b0, 8'h00);
        add_row("uart x2",    to_uart(5'd2), 1'b1, 8'hFD);
        add_row("bge taken",  b_type(3'b101, 5'd1, 5'd2, 13'd8), 1'b0, 8'h00);
        add_row("marker",     to_uart(5'd2), 1'b0, 8'h00);
        add_row("bgeu fall",  b_type(3'b111, 5'd1, 5'd2, 13'd8), 1'b0, 8'h00);
        add_row("uart x3",    to_uart(5'd3), 1'b1, 8'hF0);
        add_row("jal x5",     j_type(5'd5, 21'd8), 1'b0, 8'h00);
        add_row("marker",     to_uart(5'd2), 1'b0, 8'h00);
        add_row("uart link",  to_uart(5'd5), 1'b1, 8'h98);    // pc 148 + 4
        add_row("auipc x6",   u_type(7'h17, 5'd6, 20'h00000), 1'b0, 8'h00);
        add_row("uart auipc", to_uart(5'd6), 1'b1, 8'hA0);
        add_row("jalr x7",    i_type(7'h67, 3'b000, 5'd7, 5'd6, 12'h010), 1'b0, 8'h00);
        add_row("marker",     to_uart(5'd2), 1'b0, 8'h00);
        add_row("uart jlink", to_uart(5'd7), 1'b1, 8'hAC);    // pc 168 + 4
        add_row("sw x2",      s_type(3'b010, 5'd0, 5'd2, 12'd8), 1'b0, 8'h00);
        add_row("sb x1",      s_type(3'b000, 5'd0, 5'd1, 12'd9), 1'b0, 8'h00);
        add_row("lw x9",      i_type(7'h03, 3'b010, 5'd9, 5'd0, 12'd8), 1'b0, 8'h00);
        add_row("uart lw",    to_uart(5'd9), 1'b1, 8'hFD);
        add_row("srli 8",     i_type(7'h13, 3'b101, 5'd10, 5'd9, 12'd8), 1'b0, 8'h00);
        add_row("uart lane1", to_uart(5'd10), 1'b1, 8'h64);
        add_row("lui x11",    u_type(7'h37, 5'd11, 20'h12345), 1'b0, 8'h00);
        add_row("srli 12",    i_type(7'h13, 3'b101, 5'd11, 5'd11, 12'd12), 1'b0, 8'h00);
        add_row("uart lui",   to_uart(5'd11), 1'b1, 8'h45);
        add_row("and",        r_type(7'h00, 3'b111, 5'd3, 5'd1, 5'd11), 1'b0, 8'h00);
        add_row("uart and",   to_uart(5'd3), 1'b1, 8'h44);
        add_row("or",         r_type(7'h00, 3'b110, 5'd3, 5'd1, 5'd11), 1'b0, 8'h00);
        add_row("uart or",    to_uart(5'd3), 1'b1, 8'h65);
        add_row("srl 29",     r_type(7'h00, 3'b101, 5'd3, 5'd2, 5'd2), 1'b0, 8'h00);
        add_row("uart srl",   to_uart(5'd3), 1'b1, 8'h07);
        add_row("sra 29",     r_type(7'h20, 3'b101, 5'd3, 5'd2, 5'd2), 1'b0, 8'h00);
        add_row("uart sra",   to_uart(5'd3), 1'b1, 8'hFF);
        add_row("ori",        i_type(7'h13, 3'b110, 5'd3, 5'd1, 12'h00A), 1'b0, 8'h00);
        add_row("uart ori",   to_uart(5'd3), 1'b1, 8'h6E);
        add_row("xori",       i_type(7'h13, 3'b100, 5'd3, 5'd1, 12'h0FF), 1'b0, 8'h00);
        add_row("uart xori",  to_uart(5'd3), 1'b1, 8'h9B);
        add_row("slli 3",     i_type(7'h13, 3'b001, 5'd3, 5'd1, 12'd3), 1'b0, 8'h00);
        add_row("uart slli",  to_uart(5'd3), 1'b1, 8'h20);
        add_row("jal self",   j_type(5'd0, 21'd0), 1'b0, 8'h00);
    endtask

    task automatic check_idle();
        checks++;
        assert (o_uart_valid === 1'b0) else begin
            errors++;
            $display("ERROR: time %0t o_uart_valid expected 0 got %b", $time, o_uart_valid);
        end
    endtask

    task automatic wait_for_strobe(output bit seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (o_uart_valid !== 1'b1 && cycles < UART_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        seen = (o_uart_valid === 1'b1);
    endtask

    initial begin
        bit seen;
        bit timed_out;
        int fails;
        timed_out   = 1'b0;
        reset       = 1'b1;
        i_load_en   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        build_program();

        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            i_load_en   = 1'b1;
            i_load_addr = IMEM_AW'(i);
            i_load_data = row_word[i];
        end
        @(negedge clk);
        i_load_en = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b0;

        for (int i = 0; i < n_rows && !timed_out; i++) begin
            if (row_emit[i]) begin
                wait_for_strobe(seen);
                if (!seen) begin
                    timed_out = 1'b1;
                    $display("timeout: no UART byte arrived for row %0d (%s)", i, row_label[i]);
                end else begin
                    checks++;
                    assert (o_uart_data === row_byte[i]) else begin
                        errors++;
                        $display("ERROR: time %0t o_uart_data expected %02h got %02h (%s)",
                                 $time, row_byte[i], o_uart_data, row_label[i]);
                    end
                end
            end
        end

        if (!timed_out) begin
            repeat (END_WINDOW) @(negedge clk);
            checks++;
            assert (strobes == n_expected) else begin
                errors++;
                $display("ERROR: time %0t o_uart_valid strobes expected %0d got %0d",
                         $time, n_expected, strobes);
            end
        end

        fails = int'(uut.u_fetch.u_fetch_chk.fail_count);
        $display("checks %0d, errors %0d, assertion failures %0d, uart bytes %0d of %0d",
                 checks, errors, fails, strobes, n_expected);
        if (errors == 0 && fails == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
